// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
FAIL_MSG  ?= Regression failed
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FLIST)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== flist.f ====
src/fetch_pkg.sv
src/branch_predecode.sv
src/return_stack.sv
src/fetch_pc_gen.sv
src/ibus_port.sv
src/instr_fetch.sv
src/fetch_top.sv
test/clk_gen.sv
test/fetch_props.sv
test/fetch_tb.sv

// ==== src/branch_predecode.sv ====
`default_nettype none
`timescale 1ns/10ps

module branch_predecode (
    input  fetch_pkg::word_t  instr,
    input  fetch_pkg::addr_t  pc,
    input  fetch_pkg::addr_t  rs_top,
    output fetch_pkg::pred_t  pred
);

    logic [5:0]       opcode;
    logic [5:0]       funct;
    logic [4:0]       rs;
    logic [25:0]      index;
    fetch_pkg::addr_t pc_plus4;
    fetch_pkg::addr_t jump_target;

    assign opcode   = instr[31:26];
    assign rs       = instr[25:21];
    assign funct    = instr[5:0];
    assign index    = instr[25:0];
    assign pc_plus4 = pc + 32'd4;

    // region of pc+4 joined with the word index
    assign jump_target = {pc_plus4[31:28], index, 2'b00};

    always_comb
    begin
        pred = '0;
        case (opcode)
            fetch_pkg::OP_J:
            begin
                pred.taken  = 1'b1;
                pred.target = jump_target;
            end
            fetch_pkg::OP_JAL:
            begin
                pred.taken  = 1'b1;
                pred.target = jump_target;
                pred.push   = 1'b1;
            end
            fetch_pkg::OP_SPECIAL:
            begin
                // only a return through ra is predicted
                if (funct == fetch_pkg::FUNCT_JR && rs == fetch_pkg::REG_RA)
                begin
                    pred.taken  = 1'b1;
                    pred.target = rs_top;
                    pred.pop    = 1'b1;
                end
            end
            default:
                pred = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/fetch_pc_gen.sv ====
`default_nettype none
`timescale 1ns/10ps

module fetch_pc_gen (
    input  logic              clk,
    input  logic              reset,
    input  logic              handoff,
    input  fetch_pkg::pred_t  pair_pred,
    input  fetch_pkg::addr_t  pair_pc,
    input  logic              flush,
    input  fetch_pkg::addr_t  flush_pc,
    output logic              fetch_req,
    output fetch_pkg::addr_t  fetch_pc
);

    logic             started;
    fetch_pkg::addr_t seq_pc;

    // next aligned pair above the one just handed off
    assign seq_pc = {pair_pc[31:3], 3'b000} + 32'd8;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            started   <= 1'b0;
            fetch_req <= 1'b0;
            fetch_pc  <= '0;
        end
        else
        begin
            started   <= 1'b1;
            fetch_req <= 1'b0;
            if (!started)
            begin
                // first fetch out of reset, from address 0
                fetch_req <= 1'b1;
            end
            if (flush)
            begin
                fetch_pc  <= flush_pc;
                fetch_req <= 1'b1;
            end
            else if (handoff)
            begin
                fetch_req <= 1'b1;
                if (pair_pred.taken)
                    fetch_pc <= pair_pred.target;
                else
                    fetch_pc <= seq_pc;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    // lower address word in bits 31..0
    typedef logic [63:0] dword_t;

    localparam int RS_DEPTH = 4;
    typedef logic [$clog2(RS_DEPTH)-1:0] rs_ptr_t;

    localparam logic [5:0] OP_SPECIAL = 6'd0;
    localparam logic [5:0] OP_J       = 6'd2;
    localparam logic [5:0] OP_JAL     = 6'd3;
    localparam logic [5:0] FUNCT_JR   = 6'd8;
    localparam logic [4:0] REG_RA     = 5'd31;

    typedef struct packed {
        logic  taken;
        addr_t target;
        logic  push;
        logic  pop;
    } pred_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        word_t instr;
        logic  pred_taken;
        addr_t pred_target;
    } slot_t;

    // slot0 sits in the low bits
    typedef struct packed {
        slot_t slot1;
        slot_t slot0;
    } fetch_pair_t;

    typedef enum logic [1:0] {IDLE, REQ, RELEASE} ibus_state_t;
    typedef enum logic [1:0] {EMPTY, WAIT, FULL} fetch_state_t;

endpackage

`default_nettype wire

// ==== src/fetch_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module fetch_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    flush,
    input  fetch_pkg::addr_t        flush_pc,
    output fetch_pkg::fetch_pair_t  fetch_pair,
    output logic                    pair_valid,
    output logic                    ibus_req,
    output fetch_pkg::addr_t        ibus_addr,
    input  logic                    ibus_ack,
    input  fetch_pkg::dword_t       ibus_data
);

    logic              fetch_req;
    fetch_pkg::addr_t  fetch_pc;
    logic              rd_done;
    fetch_pkg::dword_t rd_data;
    logic              handoff;
    fetch_pkg::pred_t  pair_pred;
    fetch_pkg::addr_t  ret_addr;
    fetch_pkg::addr_t  rs_top;

    fetch_pc_gen i_fetch_pc_gen (
        .clk       (clk),
        .reset     (reset),
        .handoff   (handoff),
        .pair_pred (pair_pred),
        .pair_pc   (fetch_pair.slot0.pc),
        .flush     (flush),
        .flush_pc  (flush_pc),
        .fetch_req (fetch_req),
        .fetch_pc  (fetch_pc)
    );

    ibus_port i_ibus_port (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fetch_pc  (fetch_pc),
        .flush     (flush),
        .ibus_req  (ibus_req),
        .ibus_addr (ibus_addr),
        .ibus_ack  (ibus_ack),
        .ibus_data (ibus_data),
        .rd_done   (rd_done),
        .rd_data   (rd_data)
    );

    instr_fetch i_instr_fetch (
        .clk        (clk),
        .reset      (reset),
        .fetch_req  (fetch_req),
        .fetch_pc   (fetch_pc),
        .rd_done    (rd_done),
        .rd_data    (rd_data),
        .stall      (stall),
        .flush      (flush),
        .rs_top     (rs_top),
        .fetch_pair (fetch_pair),
        .pair_valid (pair_valid),
        .handoff    (handoff),
        .pair_pred  (pair_pred),
        .ret_addr   (ret_addr)
    );

    return_stack i_return_stack (
        .clk       (clk),
        .reset     (reset),
        .handoff   (handoff),
        .push      (pair_pred.push),
        .pop       (pair_pred.pop),
        .push_addr (ret_addr),
        .rs_top    (rs_top)
    );

endmodule

`default_nettype wire

// ==== src/ibus_port.sv ====
`default_nettype none
`timescale 1ns/10ps

module ibus_port (
    input  logic               clk,
    input  logic               reset,
    input  logic               fetch_req,
    input  fetch_pkg::addr_t   fetch_pc,
    input  logic               flush,
    output logic               ibus_req,
    output fetch_pkg::addr_t   ibus_addr,
    input  logic               ibus_ack,
    input  fetch_pkg::dword_t  ibus_data,
    output logic               rd_done,
    output fetch_pkg::dword_t  rd_data
);

    fetch_pkg::ibus_state_t state;
    logic                   pending;
    logic                   dropped;
    logic                   start;

    // a flush cancels any request not yet on the bus
    assign start    = (fetch_req | pending) & ~flush;
    assign ibus_req = (state == fetch_pkg::REQ);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state   <= fetch_pkg::IDLE;
            pending <= 1'b0;
            dropped <= 1'b0;
            rd_done <= 1'b0;
        end
        else
        begin
            rd_done <= 1'b0;
            if (flush)
                pending <= 1'b0;
            else if (fetch_req)
                pending <= 1'b1;
            case (state)
                fetch_pkg::IDLE:
                    if (start)
                    begin
                        state   <= fetch_pkg::REQ;
                        pending <= 1'b0;
                        dropped <= 1'b0;
                    end
                fetch_pkg::REQ:
                begin
                    if (flush)
                        dropped <= 1'b1;
                    if (ibus_ack)
                    begin
                        state   <= fetch_pkg::RELEASE;
                        rd_done <= ~(dropped | flush);
                    end
                end
                fetch_pkg::RELEASE:
                    if (!ibus_ack)
                        state <= fetch_pkg::IDLE;
                default:
                    state <= fetch_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == fetch_pkg::IDLE && start)
            ibus_addr <= {fetch_pc[31:3], 3'b000};
        if (state == fetch_pkg::REQ && ibus_ack)
            rd_data <= ibus_data;
    end

endmodule

`default_nettype wire

// ==== src/instr_fetch.sv ====
`default_nettype none
`timescale 1ns/10ps

module instr_fetch (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fetch_req,
    input  fetch_pkg::addr_t        fetch_pc,
    input  logic                    rd_done,
    input  fetch_pkg::dword_t       rd_data,
    input  logic                    stall,
    input  logic                    flush,
    input  fetch_pkg::addr_t        rs_top,
    output fetch_pkg::fetch_pair_t  fetch_pair,
    output logic                    pair_valid,
    output logic                    handoff,
    output fetch_pkg::pred_t        pair_pred,
    output fetch_pkg::addr_t        ret_addr
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::addr_t        buf_pc;
    fetch_pkg::dword_t       buf_data;
    fetch_pkg::addr_t        base_pc;
    fetch_pkg::addr_t        slot1_pc;
    fetch_pkg::pred_t        pred0;
    fetch_pkg::pred_t        pred1;
    logic                    valid0;
    logic                    valid1;
    logic                    act0;
    logic                    act1;

    always_ff @(posedge clk)
    begin
        if (!reset)
            state <= fetch_pkg::EMPTY;
        else if (flush)
            state <= fetch_pkg::EMPTY;
        else
        begin
            case (state)
                fetch_pkg::EMPTY:
                    if (fetch_req)
                        state <= fetch_pkg::WAIT;
                fetch_pkg::WAIT:
                    if (rd_done)
                        state <= fetch_pkg::FULL;
                fetch_pkg::FULL:
                    if (handoff)
                        state <= fetch_pkg::EMPTY;
                default:
                    state <= fetch_pkg::EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetch_req)
            buf_pc <= fetch_pc;
        if (rd_done)
            buf_data <= rd_data;
    end

    assign pair_valid = (state == fetch_pkg::FULL);
    assign handoff    = pair_valid & ~stall;

    assign base_pc  = {buf_pc[31:3], 3'b000};
    assign slot1_pc = base_pc + 32'd4;

    branch_predecode i_predecode0 (
        .instr  (buf_data[31:0]),
        .pc     (base_pc),
        .rs_top (rs_top),
        .pred   (pred0)
    );

    branch_predecode i_predecode1 (
        .instr  (buf_data[63:32]),
        .pc     (slot1_pc),
        .rs_top (rs_top),
        .pred   (pred1)
    );

    // odd-word fetch leaves only the upper word
    assign valid0 = ~buf_pc[2];
    assign act0   = valid0 & pred0.taken;
    // nothing after a taken slot 0
    assign valid1 = ~act0;
    assign act1   = valid1 & pred1.taken;

    always_comb
    begin
        fetch_pair.slot0.valid       = valid0;
        fetch_pair.slot0.pc          = base_pc;
        fetch_pair.slot0.instr       = buf_data[31:0];
        fetch_pair.slot0.pred_taken  = act0;
        fetch_pair.slot0.pred_target = act0 ? pred0.target : '0;
        fetch_pair.slot1.valid       = valid1;
        fetch_pair.slot1.pc          = slot1_pc;
        fetch_pair.slot1.instr       = buf_data[63:32];
        fetch_pair.slot1.pred_taken  = act1;
        fetch_pair.slot1.pred_target = act1 ? pred1.target : '0;
    end

    // first taken slot steers the pair, return address is its pc + 8
    always_comb
    begin
        pair_pred = '0;
        ret_addr  = '0;
        if (act0)
        begin
            pair_pred = pred0;
            ret_addr  = base_pc + 32'd8;
        end
        else if (act1)
        begin
            pair_pred = pred1;
            ret_addr  = slot1_pc + 32'd8;
        end
    end

endmodule

`default_nettype wire

// ==== src/return_stack.sv ====
`default_nettype none
`timescale 1ns/10ps

module return_stack (
    input  logic              clk,
    input  logic              reset,
    input  logic              handoff,
    input  logic              push,
    input  logic              pop,
    input  fetch_pkg::addr_t  push_addr,
    output fetch_pkg::addr_t  rs_top
);

    fetch_pkg::addr_t   entries [fetch_pkg::RS_DEPTH];
    fetch_pkg::rs_ptr_t ptr;
    fetch_pkg::rs_ptr_t ptr_up;
    fetch_pkg::rs_ptr_t ptr_down;

    // wrap both ways, oldest entry is overwritten
    assign ptr_up   = (ptr == fetch_pkg::rs_ptr_t'(fetch_pkg::RS_DEPTH - 1)) ? '0 : ptr + 1'b1;
    assign ptr_down = (ptr == '0) ? fetch_pkg::rs_ptr_t'(fetch_pkg::RS_DEPTH - 1) : ptr - 1'b1;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            ptr <= '0;
            for (int i = 0; i < fetch_pkg::RS_DEPTH; i++)
                entries[i] <= '0;
        end
        else if (handoff)
        begin
            if (push)
            begin
                entries[ptr_up] <= push_addr;
                ptr             <= ptr_up;
            end
            else if (pop)
                ptr <= ptr_down;
        end
    end

    assign rs_top = entries[ptr];

endmodule

`default_nettype wire

// ==== test/clk_gen.sv ====
`default_nettype none
`timescale 1ns/10ps

module clk_gen (
    output logic clk
);

    // 4 ns period
    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== test/fetch_props.sv ====
`default_nettype none
`timescale 1ns/10ps

module fetch_props (
    input logic                   clk,
    input logic                   reset,
    input logic                   stall,
    input logic                   flush,
    input logic                   ibus_req,
    input logic                   ibus_ack,
    input fetch_pkg::addr_t       ibus_addr,
    input logic                   pair_valid,
    input fetch_pkg::fetch_pair_t fetch_pair
);

    // four-phase handshake on the instruction bus
    req_until_ack: assert property (@(posedge clk) disable iff (!reset)
        ibus_req && !ibus_ack |=> ibus_req)
        else $error("ibus_req fell before ibus_ack rose");

    no_req_during_ack: assert property (@(posedge clk) disable iff (!reset)
        !ibus_req && ibus_ack |=> !ibus_req)
        else $error("ibus_req rose while ibus_ack was still high");

    addr_stable: assert property (@(posedge clk) disable iff (!reset)
        ibus_req && !ibus_ack |=> $stable(ibus_addr))
        else $error("ibus_addr changed during a request");

    // held pair under back-pressure
    pair_held: assert property (@(posedge clk) disable iff (!reset)
        pair_valid && stall && !flush |=> pair_valid && $stable(fetch_pair))
        else $error("fetch_pair changed while stalled");

endmodule

`default_nettype wire

// ==== test/fetch_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module fetch_tb;

    localparam int          NUM_TESTS   = 5;
    localparam int          HANDOFFS    = 60;
    localparam int          CYCLE_LIMIT = 40 * NUM_TESTS * HANDOFFS;
    localparam logic [31:0] SEED        = 32'hf8d4dd03;

    logic                   clk;
    logic                   reset;
    logic                   stall;
    logic                   flush;
    fetch_pkg::addr_t       flush_pc;
    fetch_pkg::fetch_pair_t fetch_pair;
    logic                   pair_valid;
    logic                   ibus_req;
    fetch_pkg::addr_t       ibus_addr;
    logic                   ibus_ack;
    fetch_pkg::dword_t      ibus_data;

    fetch_pkg::word_t mem [256];

    string test_names [NUM_TESTS] = '{"sequential", "jumps", "return_stack",
                                      "back_pressure", "flush"};
    int    stall_pct  [NUM_TESTS] = '{0, 0, 0, 50, 30};
    bit    flush_on   [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    int   test_idx;
    logic running;
    int   handoffs;
    int   checks;
    int   errors;
    int   test_errors;
    int   cycles;
    logic resp_busy;
    int   resp_delay;

    // software copy of the return stack and the expected fetch address
    fetch_pkg::addr_t exp_pc;
    fetch_pkg::addr_t sw_stack [fetch_pkg::RS_DEPTH];
    int               sw_ptr;

    clk_gen i_clk_gen (
        .clk (clk)
    );

    fetch_top i_fetch_top (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .flush_pc   (flush_pc),
        .fetch_pair (fetch_pair),
        .pair_valid (pair_valid),
        .ibus_req   (ibus_req),
        .ibus_addr  (ibus_addr),
        .ibus_ack   (ibus_ack),
        .ibus_data  (ibus_data)
    );

    bind fetch_top fetch_props i_fetch_props (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .ibus_req   (ibus_req),
        .ibus_ack   (ibus_ack),
        .ibus_addr  (ibus_addr),
        .pair_valid (pair_valid),
        .fetch_pair (fetch_pair)
    );

    // static prediction of one word
    function automatic fetch_pkg::pred_t predict_word(
        input fetch_pkg::word_t w,
        input fetch_pkg::addr_t pc,
        input fetch_pkg::addr_t top
    );
        fetch_pkg::pred_t p;
        fetch_pkg::addr_t next_pc;
        p       = '0;
        next_pc = pc + 32'd4;
        if (w[31:26] == fetch_pkg::OP_J || w[31:26] == fetch_pkg::OP_JAL)
        begin
            p.taken  = 1'b1;
            p.target = {next_pc[31:28], w[25:0], 2'b00};
            p.push   = (w[31:26] == fetch_pkg::OP_JAL);
        end
        else if (w[31:26] == fetch_pkg::OP_SPECIAL && w[5:0] == fetch_pkg::FUNCT_JR
                 && w[25:21] == fetch_pkg::REG_RA)
        begin
            p.taken  = 1'b1;
            p.target = top;
            p.pop    = 1'b1;
        end
        return p;
    endfunction

    // expected pair at a fetch address and the prediction that steers the next fetch
    function automatic fetch_pkg::pred_t model_pair(
        input  fetch_pkg::addr_t       pc,
        input  fetch_pkg::addr_t       top,
        output fetch_pkg::fetch_pair_t pair,
        output fetch_pkg::addr_t       ret
    );
        fetch_pkg::addr_t base;
        logic [7:0]       idx;
        fetch_pkg::pred_t p0;
        fetch_pkg::pred_t p1;
        fetch_pkg::pred_t pp;
        base = {pc[31:3], 3'b000};
        idx  = base[9:2];
        p0   = predict_word(mem[idx], base, top);
        p1   = predict_word(mem[idx + 8'd1], base + 32'd4, top);
        pair = '0;
        pp   = '0;
        ret  = '0;
        pair.slot0.valid      = ~pc[2];
        pair.slot0.pc         = base;
        pair.slot0.instr      = mem[idx];
        pair.slot0.pred_taken = pair.slot0.valid & p0.taken;
        pair.slot1.valid      = ~pair.slot0.pred_taken;
        pair.slot1.pc         = base + 32'd4;
        pair.slot1.instr      = mem[idx + 8'd1];
        pair.slot1.pred_taken = pair.slot1.valid & p1.taken;
        if (pair.slot0.pred_taken)
        begin
            pair.slot0.pred_target = p0.target;
            pp  = p0;
            ret = base + 32'd8;
        end
        else if (pair.slot1.pred_taken)
        begin
            pair.slot1.pred_target = p1.target;
            pp  = p1;
            ret = base + 32'd12;
        end
        return pp;
    endfunction

    task automatic fill_program(input int t);
        fetch_pkg::word_t w;
        logic [31:0]      r;
        int               jump_div;
        int               ret_div;
        jump_div = (t == 0) ? 0 : ((t == 2) ? 4 : 8);
        ret_div  = (t <= 1) ? 0 : ((t == 2) ? 6 : 12);
        for (int i = 0; i < 256; i++)
        begin
            w = $urandom;
            // plain words carry no control transfer
            if (w[31:26] == fetch_pkg::OP_SPECIAL || w[31:26] == fetch_pkg::OP_J
                || w[31:26] == fetch_pkg::OP_JAL)
                w[31:26] = 6'h23;
            r = $urandom;
            if (jump_div != 0 && r % jump_div == 0)
            begin
                // calls dominate in the return stack test
                if (r[8] || (t == 2 && r[9]))
                    w[31:26] = fetch_pkg::OP_JAL;
                else
                    w[31:26] = fetch_pkg::OP_J;
                w[25:0] = {18'd0, r[23:16]};
            end
            else if (ret_div != 0 && (r >> 12) % ret_div == 0)
                w = {fetch_pkg::OP_SPECIAL, fetch_pkg::REG_RA, 15'd0, fetch_pkg::FUNCT_JR};
            mem[i] = w;
        end
    endtask

    task automatic run_test(input int t);
        @(posedge clk);
        reset       <= 1'b0;
        test_idx    = t;
        exp_pc      = '0;
        sw_ptr      = 0;
        handoffs    = 0;
        test_errors = 0;
        fill_program(t);
        for (int i = 0; i < fetch_pkg::RS_DEPTH; i++)
            sw_stack[i] = '0;
        repeat (2) @(posedge clk);
        reset   <= 1'b1;
        running <= 1'b1;
        while (handoffs < HANDOFFS)
            @(posedge clk);
        running <= 1'b0;
        $display("test %s: %0d handoffs, %0d errors", test_names[t], handoffs, test_errors);
    endtask

    // memory side of the four-phase bus with 0 to 3 cycles of latency
    always @(posedge clk)
    begin
        logic [31:0] r;
        logic [7:0]  idx;
        if (!reset)
        begin
            ibus_ack  <= 1'b0;
            resp_busy = 1'b0;
        end
        else if (ibus_ack)
        begin
            if (!ibus_req)
                ibus_ack <= 1'b0;
        end
        else if (ibus_req)
        begin
            if (!resp_busy)
            begin
                r          = $urandom;
                resp_delay = int'(r[1:0]);
                resp_busy  = 1'b1;
            end
            if (resp_delay == 0)
            begin
                // reads are whole 8-byte pairs
                if (ibus_addr[2:0] != 3'b000)
                begin
                    $display("CHECK FAILED %s ibus_addr alignment: expected %h actual %h",
                             test_names[test_idx], {ibus_addr[31:3], 3'b000}, ibus_addr);
                    errors      = errors + 1;
                    test_errors = test_errors + 1;
                end
                idx       = {ibus_addr[9:3], 1'b0};
                ibus_data <= {mem[idx + 8'd1], mem[idx]};
                ibus_ack  <= 1'b1;
                resp_busy = 1'b0;
            end
            else
                resp_delay = resp_delay - 1;
        end
    end

    // decode stage stand-in
    always @(posedge clk)
    begin
        logic [31:0] r;
        r = $urandom;
        if (!running)
        begin
            stall <= 1'b0;
            flush <= 1'b0;
        end
        else
        begin
            stall <= (r % 100) < stall_pct[test_idx];
            flush <= 1'b0;
            if (flush_on[test_idx] && !flush && r[31:27] == 5'd0)
            begin
                // stall with the flush so the flushed pair is never handed off
                stall    <= 1'b1;
                flush    <= 1'b1;
                flush_pc <= {22'd0, r[17:10], 2'b00};
            end
        end
    end

    // compare every handoff with the model
    always @(posedge clk)
    begin
        fetch_pkg::fetch_pair_t exp_pair;
        fetch_pkg::pred_t       exp_pred;
        fetch_pkg::addr_t       exp_ret;
        if (running && reset && handoffs < HANDOFFS)
        begin
            if (flush)
                exp_pc = flush_pc;
            else if (pair_valid && !stall)
            begin
                exp_pred = model_pair(exp_pc, sw_stack[sw_ptr], exp_pair, exp_ret);
                checks   = checks + 1;
                if (fetch_pair.slot0 !== exp_pair.slot0)
                begin
                    $display("CHECK FAILED %s slot0 at handoff %0d: expected %h actual %h",
                             test_names[test_idx], handoffs, exp_pair.slot0, fetch_pair.slot0);
                    errors      = errors + 1;
                    test_errors = test_errors + 1;
                end
                if (fetch_pair.slot1 !== exp_pair.slot1)
                begin
                    $display("CHECK FAILED %s slot1 at handoff %0d: expected %h actual %h",
                             test_names[test_idx], handoffs, exp_pair.slot1, fetch_pair.slot1);
                    errors      = errors + 1;
                    test_errors = test_errors + 1;
                end
                if (exp_pred.push)
                begin
                    sw_ptr           = (sw_ptr + 1) % fetch_pkg::RS_DEPTH;
                    sw_stack[sw_ptr] = exp_ret;
                end
                else if (exp_pred.pop)
                    sw_ptr = (sw_ptr + fetch_pkg::RS_DEPTH - 1) % fetch_pkg::RS_DEPTH;
                exp_pc   = exp_pred.taken ? exp_pred.target : {exp_pc[31:3], 3'b000} + 32'd8;
                handoffs = handoffs + 1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, test %s stopped at %0d handoffs",
                     cycles, test_names[test_idx], handoffs);
            $display("Regression failed");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(SEED));
        reset       = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        flush_pc    = '0;
        ibus_ack    = 1'b0;
        ibus_data   = '0;
        running     = 1'b0;
        test_idx    = 0;
        handoffs    = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        cycles      = 0;
        resp_busy   = 1'b0;
        resp_delay  = 0;
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
